// ==== logic/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // store width, as carried on the store channel.
    typedef enum logic [1:0] {
        BYTE      = 2'b00,
        HALF_WORD = 2'b01,
        WORD      = 2'b10
    } access_width_t;

    typedef struct packed {
        logic        request;  // read the aligned word this cycle.
        logic [31:0] address;  // low two bits are ignored.
    } load_req_t;

    typedef struct packed {
        logic        valid;    // one cycle after request.
        logic [31:0] data;
    } load_rsp_t;

    typedef struct packed {
        logic          request;
        logic [31:0]   address;  // any byte address.
        access_width_t width;
        logic [31:0]   data;     // right aligned, byte 0 in bits 7:0.
    } store_req_t;

    typedef struct packed {
        logic        request;
        logic [31:0] address;  // bit 0 is ignored.
    } fetch_req_t;

    typedef struct packed {
        logic        valid;        // killed by invalidate in the same cycle.
        logic [31:0] instruction;
    } fetch_rsp_t;

endpackage : mem_pkg

`default_nettype wire

// ==== logic/byte_lane_map.sv ====
`default_nettype none

module byte_lane_map #(
    parameter int MEMORY_SIZE = 256
) (
    input  logic [$clog2(MEMORY_SIZE)-1:0]   base_addr_i,
    output logic [3:0][$clog2(MEMORY_SIZE)-3:0] bank_row_o,
    output logic [1:0]                       lane_shift_o
);

    localparam int ADDR_W = $clog2(MEMORY_SIZE);
    localparam int ROW_W  = ADDR_W - 2;

    logic [ROW_W-1:0] base_row;
    logic [1:0]       base_lane;

    assign base_row  = base_addr_i[ADDR_W-1:2];  // row of byte 0.
    assign base_lane = base_addr_i[1:0];         // bank of byte 0.

    // banks below the base lane hold the bytes that spill into the next row.
    // the row counter is ROW_W wide, so the top row rolls over to row 0.
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            if (b < int'(base_lane)) begin
                bank_row_o[b] = base_row + ROW_W'(1);  // next row, wraps.
            end else begin
                bank_row_o[b] = base_row;
            end
        end
    end

    assign lane_shift_o = base_lane;  // bank holding byte 0.

endmodule : byte_lane_map

`default_nettype wire

// ==== logic/memory_bank.sv ====
`default_nettype none

module memory_bank #(
    parameter int MEMORY_SIZE = 256
) (
    input  logic                            clk_i,

    input  logic                            wr_en_i,
    input  logic [$clog2(MEMORY_SIZE/4)-1:0] wr_row_i,
    input  logic [7:0]                      wr_data_i,

    input  logic [$clog2(MEMORY_SIZE/4)-1:0] rd_a_row_i,
    output logic [7:0]                      rd_a_data_o,

    input  logic [$clog2(MEMORY_SIZE/4)-1:0] rd_b_row_i,
    output logic [7:0]                      rd_b_data_o
);

    localparam int ROWS = MEMORY_SIZE / 4;

    // one byte lane of the whole memory.
    logic [7:0] bank_mem [ROWS] = '{default: 8'h00};

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            bank_mem[wr_row_i] <= wr_data_i;
        end
    end

    // both read ports sample before the write lands, so a same-row
    // read returns the old byte.
    always_ff @(posedge clk_i) begin
        rd_a_data_o <= bank_mem[rd_a_row_i];  // load side.
        rd_b_data_o <= bank_mem[rd_b_row_i];  // fetch side.
    end

endmodule : memory_bank

`default_nettype wire

// ==== logic/store_port.sv ====
`default_nettype none

module store_port (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  mem_pkg::store_req_t  store_req_i,
    input  logic [1:0]           lane_shift_i,

    output logic [3:0]           wr_en_o,
    output logic [3:0][7:0]      wr_data_o,
    output logic                 store_done_o
);

    import mem_pkg::*;

    logic [3:0] lane_en;  // enables in access order, byte 0 first.

    always_comb begin
        case (store_req_i.width)
            BYTE:      lane_en = 4'b0001;
            HALF_WORD: lane_en = 4'b0011;
            WORD:      lane_en = 4'b1111;
            default:   lane_en = 4'b0000;  // unused encoding writes nothing.
        endcase
    end

    // rotate enables and data from access order into bank order.
    // bank b carries byte (b - shift) mod 4 of the access.
    always_comb begin : lane_rotate
        logic [1:0] byte_idx;

        for (int b = 0; b < 4; b++) begin
            byte_idx     = 2'(b) - lane_shift_i;
            wr_en_o[b]   = store_req_i.request & lane_en[byte_idx];
            wr_data_o[b] = store_req_i.data[byte_idx*8 +: 8];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            store_done_o <= 1'b0;
        end else begin
            store_done_o <= store_req_i.request;  // one pulse per request.
        end
    end

endmodule : store_port

`default_nettype wire

// ==== logic/load_port.sv ====
`default_nettype none

module load_port #(
    parameter int MEMORY_SIZE = 256
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    input  mem_pkg::load_req_t              load_req_i,
    input  logic [3:0][7:0]                 rd_data_i,
    output mem_pkg::load_rsp_t              load_rsp_o,

    output logic [$clog2(MEMORY_SIZE)-1:0]  aligned_addr_o
);

    localparam int ADDR_W = $clog2(MEMORY_SIZE);

    logic load_valid_q;

    // loads are word aligned, so every bank reads the same row.
    assign aligned_addr_o = {load_req_i.address[ADDR_W-1:2], 2'b00};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            load_valid_q <= 1'b0;
        end else begin
            load_valid_q <= load_req_i.request;
        end
    end

    // with no rotation, bank order is already byte order.
    always_comb begin
        load_rsp_o.valid = load_valid_q;
        load_rsp_o.data  = rd_data_i;  // bank 0 in the low byte.
    end

endmodule : load_port

`default_nettype wire

// ==== logic/fetch_port.sv ====
`default_nettype none

module fetch_port #(
    parameter int MEMORY_SIZE = 256
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    input  mem_pkg::fetch_req_t             fetch_req_i,
    input  logic                            invalidate_i,

    input  logic [1:0]                      lane_shift_i,
    input  logic [3:0][7:0]                 rd_data_i,
    output logic [$clog2(MEMORY_SIZE)-1:0]  aligned_addr_o,

    output mem_pkg::fetch_rsp_t             fetch_rsp_o
);

    localparam int ADDR_W = $clog2(MEMORY_SIZE);

    logic        fetch_pend_q;  // a fetch was sampled last edge.
    logic [1:0]  shift_q;       // lane of byte 0 for that fetch.
    logic [31:0] instr;

    // instructions sit on halfword boundaries.
    assign aligned_addr_o = {fetch_req_i.address[ADDR_W-1:1], 1'b0};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fetch_pend_q <= 1'b0;
        end else begin
            fetch_pend_q <= fetch_req_i.request;
        end
    end

    always_ff @(posedge clk_i) begin
        shift_q <= lane_shift_i;  // travels with the bank read.
    end

    // undo the lane rotation. byte k comes from bank (shift + k) mod 4.
    always_comb begin : lane_unrotate
        logic [1:0] bank_idx;

        for (int k = 0; k < 4; k++) begin
            bank_idx          = shift_q + 2'(k);
            instr[k*8 +: 8]   = rd_data_i[bank_idx];
        end
    end

    // instruction reads zero unless a fetch is pending, so it is zero out of reset.
    always_comb begin
        fetch_rsp_o.valid       = fetch_pend_q & ~invalidate_i;  // killed this cycle.
        fetch_rsp_o.instruction = fetch_pend_q ? instr : 32'h0000_0000;
    end

endmodule : fetch_port

`default_nettype wire

// ==== logic/system_memory.sv ====
`default_nettype none

module system_memory #(
    parameter int MEMORY_SIZE = 256
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  mem_pkg::load_req_t   load_req_i,
    output mem_pkg::load_rsp_t   load_rsp_o,

    input  mem_pkg::store_req_t  store_req_i,
    output logic                 store_done_o,

    input  mem_pkg::fetch_req_t  fetch_req_i,
    input  logic                 invalidate_i,
    output mem_pkg::fetch_rsp_t  fetch_rsp_o
);

    localparam int ADDR_W = $clog2(MEMORY_SIZE);
    localparam int ROW_W  = ADDR_W - 2;

    logic [3:0][ROW_W-1:0] store_row;
    logic [1:0]            store_shift;
    logic [3:0]            wr_en;
    logic [3:0][7:0]       wr_data;

    logic [ADDR_W-1:0]     load_addr;
    logic [3:0][ROW_W-1:0] load_row;
    logic [3:0][7:0]       load_data;

    logic [ADDR_W-1:0]     fetch_addr;
    logic [3:0][ROW_W-1:0] fetch_row;
    logic [1:0]            fetch_shift;
    logic [3:0][7:0]       fetch_data;

    byte_lane_map #(.MEMORY_SIZE(MEMORY_SIZE)) i_store_map (
        .base_addr_i  (store_req_i.address[ADDR_W-1:0]),
        .bank_row_o   (store_row),
        .lane_shift_o (store_shift)
    );

    byte_lane_map #(.MEMORY_SIZE(MEMORY_SIZE)) i_load_map (
        .base_addr_i  (load_addr),
        .bank_row_o   (load_row),
        .lane_shift_o ()  // aligned, always lane 0.
    );

    byte_lane_map #(.MEMORY_SIZE(MEMORY_SIZE)) i_fetch_map (
        .base_addr_i  (fetch_addr),
        .bank_row_o   (fetch_row),
        .lane_shift_o (fetch_shift)
    );

    // port A serves loads, port B serves fetches.
    for (genvar b = 0; b < 4; b++) begin : g_bank
        memory_bank #(.MEMORY_SIZE(MEMORY_SIZE)) i_bank (
            .clk_i       (clk_i),
            .wr_en_i     (wr_en[b]),
            .wr_row_i    (store_row[b]),
            .wr_data_i   (wr_data[b]),
            .rd_a_row_i  (load_row[b]),
            .rd_a_data_o (load_data[b]),
            .rd_b_row_i  (fetch_row[b]),
            .rd_b_data_o (fetch_data[b])
        );
    end

    store_port i_store_port (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .store_req_i  (store_req_i),
        .lane_shift_i (store_shift),
        .wr_en_o      (wr_en),
        .wr_data_o    (wr_data),
        .store_done_o (store_done_o)
    );

    load_port #(.MEMORY_SIZE(MEMORY_SIZE)) i_load_port (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .load_req_i     (load_req_i),
        .rd_data_i      (load_data),
        .load_rsp_o     (load_rsp_o),
        .aligned_addr_o (load_addr)
    );

    fetch_port #(.MEMORY_SIZE(MEMORY_SIZE)) i_fetch_port (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .fetch_req_i    (fetch_req_i),
        .invalidate_i   (invalidate_i),
        .lane_shift_i   (fetch_shift),
        .rd_data_i      (fetch_data),
        .aligned_addr_o (fetch_addr),
        .fetch_rsp_o    (fetch_rsp_o)
    );

endmodule : system_memory

`default_nettype wire

// ==== testbench/mem_model.svh ====
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

// byte array reference for the whole memory.
logic [7:0] model_mem [MEM_SIZE] = '{default: 8'h00};

// address of byte k of an access. the size is a power of two, so
// truncation is the modulo.
function automatic logic [ADDR_W-1:0] byte_addr(input logic [31:0] base, input int k);
    return ADDR_W'(base + 32'(k));
endfunction

function automatic void model_store(input logic [31:0] addr, input access_width_t width,
                                    input logic [31:0] data);
    int n_bytes;
    case (width)
        BYTE:      n_bytes = 1;
        HALF_WORD: n_bytes = 2;
        WORD:      n_bytes = 4;
        default:   n_bytes = 0;
    endcase
    for (int k = 0; k < n_bytes; k++) begin
        model_mem[byte_addr(addr, k)] = data[k*8 +: 8];  // byte 0 from the low bits.
    end
endfunction

function automatic logic [31:0] read_four(input logic [31:0] base);
    logic [31:0] word;
    for (int k = 0; k < 4; k++) begin
        word[k*8 +: 8] = model_mem[byte_addr(base, k)];
    end
    return word;
endfunction

function automatic logic [31:0] model_load(input logic [31:0] addr);
    return read_four({addr[31:2], 2'b00});  // loads are word aligned.
endfunction

function automatic logic [31:0] model_fetch(input logic [31:0] addr);
    return read_four({addr[31:1], 1'b0});  // halfword aligned.
endfunction

`endif

// ==== testbench/tb_system_memory.sv ====
`default_nettype none

module tb_system_memory;

    import mem_pkg::*;

    localparam int MEM_SIZE      = 64;  // small, so wraparound comes quickly.
    localparam int ADDR_W        = $clog2(MEM_SIZE);
    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 16;
    localparam int N_WIDTH       = 24;
    localparam int N_UNALIGNED   = 16;
    localparam int N_FETCH       = 32;
    localparam int N_INVALIDATE  = 8;
    localparam int N_COLLISION   = 8;
    // each test ends with two idle cycles.
    localparam int TEST_CYCLES   = RESET_CYCLES + 2 * N_WIDTH + 3 * (N_UNALIGNED + 4)
                                 + N_FETCH + 3 * N_INVALIDATE + 2 * N_COLLISION + 6 * 2;
    localparam int WATCHDOG_TIME = TEST_CYCLES * CLK_PERIOD + 400;

    logic        clk_i;
    logic        rst_n_i;
    load_req_t   load_req;
    load_rsp_t   load_rsp;
    store_req_t  store_req;
    logic        store_done;
    fetch_req_t  fetch_req;
    logic        invalidate;
    fetch_rsp_t  fetch_rsp;

    logic        exp_done;
    logic        exp_load_v;
    logic [31:0] exp_load_d;
    logic        exp_fetch_v;
    logic [31:0] exp_fetch_i;

    string       test_name;
    int          err_count;
    int          errs_at_start;
    int          pass_count;
    int          fail_count;

    `include "mem_model.svh"

    system_memory #(.MEMORY_SIZE(MEM_SIZE)) i_dut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .load_req_i   (load_req),
        .load_rsp_o   (load_rsp),
        .store_req_i  (store_req),
        .store_done_o (store_done),
        .fetch_req_i  (fetch_req),
        .invalidate_i (invalidate),
        .fetch_rsp_o  (fetch_rsp)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // expected responses for the next cycle. reads use the model
    // before this edge's store lands, and nothing responds under reset.
    always @(posedge clk_i) begin
        exp_done    <= rst_n_i & store_req.request;
        exp_load_v  <= rst_n_i & load_req.request;
        exp_load_d  <= model_load(load_req.address);
        exp_fetch_v <= rst_n_i & fetch_req.request;
        exp_fetch_i <= model_fetch(fetch_req.address);
        if (store_req.request) begin
            model_store(store_req.address, store_req.width, store_req.data);
        end
    end

    function automatic void flag_error(input string what, input logic [31:0] expected,
                                       input logic [31:0] actual);
        err_count++;
        $display("** Error: %s: %s expected %h, actual %h", test_name, what, expected, actual);
    endfunction

    // outputs settle after the rising edge, so checks run on the falling one.
    a_done: assert property (@(negedge clk_i) store_done == exp_done)
        else flag_error("store done", 32'(exp_done), 32'(store_done));
    a_load_valid: assert property (@(negedge clk_i) load_rsp.valid == exp_load_v)
        else flag_error("load valid", 32'(exp_load_v), 32'(load_rsp.valid));
    a_load_data: assert property (@(negedge clk_i) exp_load_v |-> load_rsp.data == exp_load_d)
        else flag_error("load data", exp_load_d, load_rsp.data);
    a_fetch_valid: assert property (@(negedge clk_i)
                                    fetch_rsp.valid == (exp_fetch_v & ~invalidate))
        else flag_error("fetch valid", 32'(exp_fetch_v & ~invalidate), 32'(fetch_rsp.valid));
    a_fetch_instr: assert property (@(negedge clk_i)
                                    exp_fetch_v && !invalidate
                                    |-> fetch_rsp.instruction == exp_fetch_i)
        else flag_error("fetch instruction", exp_fetch_i, fetch_rsp.instruction);
    a_reset_instr: assert property (@(negedge clk_i) !rst_n_i |-> fetch_rsp.instruction == 32'h0)
        else flag_error("reset instruction", 32'h0, fetch_rsp.instruction);

    function automatic access_width_t width_of(input int sel);
        case (sel)
            0:       return BYTE;
            1:       return HALF_WORD;
            default: return WORD;
        endcase
    endfunction

    // one clock, with every request dropped unless the caller raises it again.
    task automatic next_cycle();
        @(posedge clk_i);
        store_req.request <= 1'b0;
        load_req.request  <= 1'b0;
        fetch_req.request <= 1'b0;
        invalidate        <= 1'b0;
    endtask

    task automatic send_store(input logic [31:0] addr, input access_width_t width,
                              input logic [31:0] data);
        store_req <= '{request: 1'b1, address: addr, width: width, data: data};
    endtask

    task automatic send_load(input logic [31:0] addr);
        load_req <= '{request: 1'b1, address: addr};
    endtask

    task automatic send_fetch(input logic [31:0] addr);
        fetch_req <= '{request: 1'b1, address: addr};
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errs_at_start = err_count;
    endtask

    task automatic end_test();
        next_cycle();
        next_cycle();  // last response is checked by now.
        if (err_count == errs_at_start) begin
            pass_count++;
            $display("test %s: passed", test_name);
        end else begin
            fail_count++;
            $display("test %s: failed, %0d errors", test_name, err_count - errs_at_start);
        end
    endtask

    task automatic reset_phase();
        begin_test("reset");
        for (int i = 0; i < RESET_CYCLES; i++) begin
            next_cycle();
            if (i < RESET_CYCLES - 1) begin
                // requests under reset raise no response, memory still takes the store.
                send_store($urandom % MEM_SIZE, WORD, $urandom);
                send_load($urandom % MEM_SIZE);
                send_fetch($urandom % MEM_SIZE);
            end
        end
        rst_n_i <= 1'b1;
        end_test();  // covers the first cycle after reset.
    endtask

    task automatic store_width_sweep();
        logic [31:0] addr;
        begin_test("store widths");
        for (int i = 0; i < N_WIDTH; i++) begin
            addr = ($urandom % MEM_SIZE) & ~32'h3;
            next_cycle();
            send_store(addr, width_of(i % 3), $urandom);
            next_cycle();
            send_load(addr);
        end
        end_test();
    endtask

    task automatic unaligned_stores();
        logic [31:0]   addr;
        access_width_t width;
        begin_test("unaligned stores");
        for (int i = 0; i < N_UNALIGNED + 4; i++) begin
            if (i < 3) begin
                addr  = 32'(MEM_SIZE - 1 - i);  // top of memory, wraps to 0.
                width = WORD;
            end else if (i == 3) begin
                addr  = 32'(MEM_SIZE - 1);
                width = HALF_WORD;
            end else begin
                addr  = (($urandom % (MEM_SIZE / 4)) * 4) + 1 + ($urandom % 3);
                width = width_of($urandom % 3);
            end
            next_cycle();
            send_store(addr, width, $urandom);
            next_cycle();
            send_load(addr);
            next_cycle();
            send_load(addr + 4);  // the following word.
        end
        end_test();
    endtask

    task automatic fetch_stream();
        begin_test("fetch");
        for (int i = 0; i < N_FETCH; i++) begin
            next_cycle();
            send_fetch($urandom % MEM_SIZE);  // back to back.
        end
        end_test();
    endtask

    task automatic invalidate_sequence();
        begin_test("invalidate");
        for (int i = 0; i < N_INVALIDATE; i++) begin
            next_cycle();
            send_fetch($urandom % MEM_SIZE);
            next_cycle();
            invalidate <= 1'b1;  // kills the response now on the bus.
            send_fetch($urandom % MEM_SIZE);
            next_cycle();
        end
        end_test();
    endtask

    task automatic store_load_collision();
        logic [31:0] addr;
        begin_test("store and load collision");
        for (int i = 0; i < N_COLLISION; i++) begin
            addr = ($urandom % MEM_SIZE) & ~32'h3;
            next_cycle();
            send_store(addr, width_of(i % 3), $urandom);
            send_load(addr);  // old word.
            next_cycle();
            send_load(addr);  // new word.
        end
        end_test();
    endtask

    initial begin
        void'($urandom(32'h592e7a84));
        rst_n_i     = 1'b0;
        load_req    = '0;
        store_req   = '0;
        fetch_req   = '0;
        invalidate  = 1'b0;
        exp_done    = 1'b0;
        exp_load_v  = 1'b0;
        exp_load_d  = '0;
        exp_fetch_v = 1'b0;
        exp_fetch_i = '0;
        err_count   = 0;
        pass_count  = 0;
        fail_count  = 0;
        reset_phase();
        store_width_sweep();
        unaligned_stores();
        fetch_stream();
        invalidate_sequence();
        store_load_collision();
        $display("tests passed: %0d, failed: %0d, errors: %0d", pass_count, fail_count, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog: tests did not finish within %0d time units", WATCHDOG_TIME);
        $display("Simulation failed");
        $finish;
    end

endmodule : tb_system_memory

`default_nettype wire

// ==== build.f ====
+incdir+testbench
logic/mem_pkg.sv
logic/byte_lane_map.sv
logic/memory_bank.sv
logic/store_port.sv
logic/load_port.sv
logic/fetch_port.sv
logic/system_memory.sv
testbench/tb_system_memory.sv

// ==== run.sh ====
#!/bin/sh
# compiles the testbench with Verilator and runs it, logging to sim.log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_system_memory -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vtb_system_memory > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
